// File: src/fpdiv_defs.svh
// shared constants for the fp32 SRT divider
// include wherever iteration counts, widths or flag positions are needed
`ifndef FPDIV_DEFS_SVH
`define FPDIV_DEFS_SVH

// radix-4 recurrence, two quotient bits per step
`define FPDIV_ITERS 14
`define FPDIV_QW    28   // raw quotient bits
`define FPDIV_RW    28   // residual, 2 integer + 26 fraction bits, two's complement

// single precision exponent bias
`define FPDIV_BIAS  127

// bit positions in the 5-bit flags word
`define FLAG_INVALID   4
`define FLAG_DIVZERO   3
`define FLAG_OVERFLOW  2
`define FLAG_UNDERFLOW 1
`define FLAG_INEXACT   0

`endif

// File: src/fpdiv_pkg.sv
// types shared by the divider datapath and its testbench model
// import with a wildcard in the module header where fp32 words are taken apart
package fpdiv_pkg;

  // one IEEE-754 single precision word, seen either as raw bits or as its fields
  // unpack reads the fields, round/pack builds the result through them,
  // the ctrl registers only ever move the raw word
  typedef union packed {
    logic [31:0] word;    // raw bus view
    struct packed {
      logic        sign;      // 1 = negative
      logic [7:0]  exponent;  // biased, 0 and 255 are reserved
      logic [22:0] fraction;  // hidden bit not stored
    } f;
  } fp32_u;

endpackage

// File: src/fpdiv_ifs.sv
// internal bundles of the divider
// srt_iter_if runs between the controller and the SRT core,
// fp_side_if carries the unpacked side info to round/pack
`timescale 1ns/10ps
`include "fpdiv_defs.svh"

interface srt_iter_if;
  logic                  start;          // one-cycle pulse from ctrl
  logic [23:0]           mant_dividend;  // 1.f, held while the core runs
  logic [23:0]           mant_divisor;
  logic                  done;           // one-cycle pulse from core
  logic [`FPDIV_QW-1:0]  quot;           // valid while done is high
  logic                  rem_nonzero;    // sticky source for rounding

  modport ctrl (
    output start,
    input  done
  );

  modport core (
    input  start, mant_dividend, mant_divisor,
    output done, quot, rem_nonzero
  );
endinterface

interface fp_side_if;
  logic              sign;           // xor of operand signs
  logic signed [9:0] exp_diff;       // ea - eb + bias, may go out of range
  logic              is_special;     // zero, inf or nan result
  logic [31:0]       special_word;   // result used when is_special
  logic [4:0]        special_flags;

  modport src (output sign, exp_diff, is_special, special_word, special_flags);
  modport dst (input  sign, exp_diff, is_special, special_word, special_flags);
endinterface

// File: src/fp_unpack.sv
// operand unpack for the divider, purely combinational
// classifies both operands, forms sign and exponent difference,
// hands left-aligned mantissas to the SRT core and the special result to round/pack
`timescale 1ns/10ps
`include "fpdiv_defs.svh"

module fp_unpack
  import fpdiv_pkg::*;
(
  input  fp32_u         a,       // dividend
  input  fp32_u         b,       // divisor
  fp_side_if.src        side,
  output logic [23:0]   mant_a,
  output logic [23:0]   mant_b
);

  logic a_zero, a_inf, a_nan, a_norm;
  logic b_zero, b_inf, b_nan, b_norm;
  logic res_sign;

  // subnormals count as zero
  assign a_zero = (a.f.exponent == 8'h00);
  assign b_zero = (b.f.exponent == 8'h00);
  assign a_inf  = (a.f.exponent == 8'hff) && (a.f.fraction == 23'h0);
  assign b_inf  = (b.f.exponent == 8'hff) && (b.f.fraction == 23'h0);
  assign a_nan  = (a.f.exponent == 8'hff) && (a.f.fraction != 23'h0);
  assign b_nan  = (b.f.exponent == 8'hff) && (b.f.fraction != 23'h0);
  assign a_norm = !a_zero && (a.f.exponent != 8'hff);
  assign b_norm = !b_zero && (b.f.exponent != 8'hff);

  assign res_sign  = a.f.sign ^ b.f.sign;
  assign side.sign = res_sign;

  // hidden bit restored, specials get 1.0 so the recurrence stays bounded
  assign mant_a = a_norm ? {1'b1, a.f.fraction} : 24'h80_0000;
  assign mant_b = b_norm ? {1'b1, b.f.fraction} : 24'h80_0000;

  // biased, one too high when the quotient ends up below one
  assign side.exp_diff = 10'(a.f.exponent) - 10'(b.f.exponent) + 10'(`FPDIV_BIAS);

  always_comb begin
    side.is_special    = 1'b1;
    side.special_word  = {res_sign, 31'h0};   // signed zero by default
    side.special_flags = 5'b0;
    if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
      side.special_word = 32'h7fc0_0000;      // canonical quiet nan
      side.special_flags[`FLAG_INVALID] = 1'b1;
    end else if (a_inf) begin
      side.special_word = {res_sign, 8'hff, 23'h0};  // inf / finite
    end else if (b_zero) begin
      side.special_word = {res_sign, 8'hff, 23'h0};  // finite nonzero / 0
      side.special_flags[`FLAG_DIVZERO] = 1'b1;
    end else if (a_zero || b_inf) begin
      side.special_word = {res_sign, 31'h0};  // 0 / x, finite / inf
    end else begin
      side.is_special = 1'b0;                 // both normal, datapath result
    end
  end

endmodule

// File: src/srt_qsel_table.sv
// radix-4 SRT quotient digit selection, digit set -2..+2 (redundancy 2/3)
// r_est is 4w truncated to 3 integer and 4 fraction bits,
// d_idx the three divisor bits below the leading one of 0.1xxx
`timescale 1ns/10ps

module srt_qsel_table (
  input  logic [6:0] r_est,   // two's complement, units of 1/16
  input  logic [2:0] d_idx,   // divisor interval, [8+i, 9+i)/16
  output logic [2:0] digit    // {sign, magnitude}
);

  logic signed [7:0] m2, m1, m0, mn1;   // lower bounds for digits 2, 1, 0, -1
  logic signed [7:0] y;

  assign y = 8'(signed'(r_est));   // sign extend

  always_comb begin
    case (d_idx)
      3'd0:    begin m2 = 8'sd12; m1 = 8'sd4; m0 = -8'sd4; mn1 = -8'sd13; end
      3'd1:    begin m2 = 8'sd14; m1 = 8'sd4; m0 = -8'sd6; mn1 = -8'sd15; end
      3'd2:    begin m2 = 8'sd15; m1 = 8'sd4; m0 = -8'sd6; mn1 = -8'sd16; end
      3'd3:    begin m2 = 8'sd16; m1 = 8'sd4; m0 = -8'sd6; mn1 = -8'sd18; end
      3'd4:    begin m2 = 8'sd18; m1 = 8'sd6; m0 = -8'sd8; mn1 = -8'sd20; end
      3'd5:    begin m2 = 8'sd20; m1 = 8'sd6; m0 = -8'sd8; mn1 = -8'sd20; end
      3'd6:    begin m2 = 8'sd20; m1 = 8'sd8; m0 = -8'sd8; mn1 = -8'sd22; end
      default: begin m2 = 8'sd24; m1 = 8'sd8; m0 = -8'sd8; mn1 = -8'sd24; end
    endcase
  end

  // pick the digit whose interval holds the estimate
  // estimate error is below 1/16 since the residual is non-redundant
  always_comb begin
    if (y >= m2) begin
      digit = 3'b0_10;        // +2
    end else if (y >= m1) begin
      digit = 3'b0_01;        // +1
    end else if (y >= m0) begin
      digit = 3'b0_00;        // 0
    end else if (y >= mn1) begin
      digit = 3'b1_01;        // -1
    end else begin
      digit = 3'b1_10;        // -2
    end
  end

endmodule

// File: src/srt_radix4_core.sv
// radix-4 SRT iteration core
// start loads the residual, 14 steps follow, done pulses with quot valid
// quotient assembled on the fly from Q/QM, no final carry-propagate conversion
`timescale 1ns/10ps
`include "fpdiv_defs.svh"

module srt_radix4_core (
  input  logic      clk,
  input  logic      rst,
  srt_iter_if.core  iter
);

  logic [`FPDIV_RW-1:0] resid;       // w, |w| <= 2/3 d
  logic [`FPDIV_QW-1:0] q_reg;       // Q
  logic [`FPDIV_QW-1:0] qm_reg;      // QM = Q - ulp
  logic [3:0]           cnt;
  logic                 busy;

  logic [`FPDIV_RW-1:0] div_d;       // 0.1xxx, divisor scaled into [1/2, 1)
  logic [`FPDIV_RW+1:0] y;           // 4w, one extra integer bit
  logic [`FPDIV_RW+1:0] dm;          // |digit| * d
  logic [`FPDIV_RW+1:0] y_next;
  logic [2:0]           digit;
  logic [1:0]           mag;
  logic                 neg_digit;
  logic [`FPDIV_QW-1:0] q_next, qm_next;
  logic                 resid_neg;
  logic [`FPDIV_RW-1:0] rem_corr;

  assign div_d = {2'b00, iter.mant_divisor, 2'b00};
  assign y     = {resid, 2'b00};

  srt_qsel_table srt_qsel_table_i (
    .r_est (resid[`FPDIV_RW-2 -: 7]),   // 4w to 1/16
    .d_idx (iter.mant_divisor[22:20]),  // bits after the leading one
    .digit (digit)
  );

  assign neg_digit = digit[2];
  assign mag       = digit[1:0];

  // divisor multiple, 0 / d / 2d
  always_comb begin
    case (mag)
      2'd1:    dm = {2'b00, div_d};
      2'd2:    dm = {1'b0, div_d, 1'b0};
      default: dm = '0;
    endcase
  end

  // w' = 4w - q*d
  assign y_next = neg_digit ? (y + dm) : (y - dm);

  // on-the-fly conversion
  always_comb begin
    if (!neg_digit) begin
      q_next  = {q_reg[`FPDIV_QW-3:0], mag};
      qm_next = (mag == 2'd0) ? {qm_reg[`FPDIV_QW-3:0], 2'd3}
                              : {q_reg[`FPDIV_QW-3:0], mag - 2'd1};
    end else begin
      q_next  = {qm_reg[`FPDIV_QW-3:0], ~mag + 2'd1};   // 4 - |q|
      qm_next = {qm_reg[`FPDIV_QW-3:0], ~mag};          // 3 - |q|
    end
  end

  // first digit is always positive, so Q/QM start at zero
  always_ff @(posedge clk) begin
    if (iter.start) begin
      resid  <= {4'b0000, iter.mant_dividend};   // x/8, inside the bound
      q_reg  <= '0;
      qm_reg <= '0;
    end else if (busy) begin
      resid  <= y_next[`FPDIV_RW-1:0];
      q_reg  <= q_next;
      qm_reg <= qm_next;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      busy      <= 1'b0;
      cnt       <= 4'd0;
      iter.done <= 1'b0;
    end else begin
      iter.done <= 1'b0;                      // pulse
      if (iter.start) begin
        busy <= 1'b1;
        cnt  <= 4'd0;
      end else if (busy) begin
        cnt <= cnt + 4'd1;
        if (cnt == 4'(`FPDIV_ITERS - 1)) begin   // last step
          busy      <= 1'b0;
          iter.done <= 1'b1;
        end
      end
    end
  end

  // final correction, negative residual means Q overshot by one ulp
  assign resid_neg        = resid[`FPDIV_RW-1];
  assign rem_corr         = resid_neg ? (resid + div_d) : resid;
  assign iter.quot        = resid_neg ? qm_reg : q_reg;
  assign iter.rem_nonzero = |rem_corr;

endmodule

// File: src/fp_round_pack.sv
// normalize, round to nearest even and pack the fp32 result
// quot is x/(4d) as a 28-bit fraction, so its leading one sits at bit 26 or 25
// special results from unpack take priority over the datapath
`timescale 1ns/10ps
`include "fpdiv_defs.svh"

module fp_round_pack
  import fpdiv_pkg::*;
(
  input  logic [`FPDIV_QW-1:0] quot,
  input  logic                 rem_nonzero,
  fp_side_if.dst               side,
  output fp32_u                result,
  output logic [4:0]           flags
);

  logic                  below_one;
  logic [`FPDIV_QW-1:0]  nq;          // normalized, leading one at bit 26
  logic [23:0]           mant;
  logic                  guard;
  logic                  sticky;
  logic                  round_up;
  logic [24:0]           mant_r;      // with carry-out
  logic                  carry;
  logic [22:0]           frac;
  logic signed [9:0]     exp_n;
  logic signed [9:0]     exp_r;
  logic                  inexact;

  assign below_one = ~quot[`FPDIV_QW-2];   // x < d
  assign nq        = below_one ? {quot[`FPDIV_QW-2:0], 1'b0} : quot;
  assign exp_n     = side.exp_diff - {9'd0, below_one};

  assign mant     = nq[`FPDIV_QW-2 -: 24];
  assign guard    = nq[2];
  assign sticky   = (|nq[1:0]) | rem_nonzero;
  assign round_up = guard & (sticky | mant[0]);   // ties go to even
  assign inexact  = guard | sticky;

  assign mant_r = {1'b0, mant} + {24'd0, round_up};
  assign carry  = mant_r[24];                      // 1.111.. rolled to 10.000..
  assign frac   = carry ? mant_r[23:1] : mant_r[22:0];
  assign exp_r  = exp_n + {9'd0, carry};

  always_comb begin
    result.f.sign     = side.sign;
    result.f.exponent = exp_r[7:0];
    result.f.fraction = frac;
    flags             = 5'b0;
    flags[`FLAG_INEXACT] = inexact;
    if (side.is_special) begin
      result.word = side.special_word;
      flags       = side.special_flags;
    end else if (exp_r >= 10'sd255) begin
      result.f.exponent = 8'hff;          // signed inf
      result.f.fraction = 23'h0;
      flags[`FLAG_OVERFLOW] = 1'b1;
      flags[`FLAG_INEXACT]  = 1'b1;
    end else if (exp_r <= 10'sd0) begin
      result.f.exponent = 8'h00;          // flush to signed zero
      result.f.fraction = 23'h0;
      flags[`FLAG_UNDERFLOW] = 1'b1;
      flags[`FLAG_INEXACT]   = 1'b1;
    end
  end

endmodule

// File: src/fpdiv_ctrl.sv
// four-phase req/ack controller for the divider
// captures operands on req, pulses start, latches the packed result on done,
// holds ack until the requester drops req
`timescale 1ns/10ps

module fpdiv_ctrl
  import fpdiv_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         req,
  output logic         ack,
  input  logic [31:0]  dividend_in,
  input  logic [31:0]  divisor_in,
  output fp32_u        op_a,
  output fp32_u        op_b,
  srt_iter_if.ctrl     iter,
  input  fp32_u        res_in,
  input  logic [4:0]   flags_in,
  output logic [31:0]  quotient,
  output logic [4:0]   flags
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_busy  = 2'd1;   // core iterating
  localparam logic [1:0] st_acked = 2'd2;   // result held, waiting for req low

  logic [1:0] state;
  logic       take;

  assign take = (state == st_idle) && req;

  // operands stay put for the whole division
  always_ff @(posedge clk) begin
    if (take) begin
      op_a.word <= dividend_in;
      op_b.word <= divisor_in;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state      <= st_idle;
      ack        <= 1'b0;
      iter.start <= 1'b0;
      quotient   <= 32'h0;
      flags      <= 5'h0;
    end else begin
      iter.start <= take;                  // high for the cycle after capture
      case (state)
        st_idle:  if (req) state <= st_busy;
        st_busy: begin
          if (iter.done) begin
            quotient <= res_in.word;       // unpack/round are combinational
            flags    <= flags_in;
            ack      <= 1'b1;
            state    <= st_acked;
          end
        end
        st_acked: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: src/fp32_divider.sv
// fp32 divider top, radix-4 SRT, round to nearest even
// plain req/ack ports, result 16 edges after req is sampled
// only wiring here, the work is in ctrl, unpack, core and round/pack
`timescale 1ns/10ps

module fp32_divider
  import fpdiv_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         req,
  output logic         ack,
  input  logic [31:0]  dividend,
  input  logic [31:0]  divisor,
  output logic [31:0]  quotient,
  output logic [4:0]   flags
);

  fp32_u      op_a, op_b;      // registered operands
  fp32_u      res_word;        // packed result, combinational
  logic [4:0] res_flags;

  srt_iter_if iter_bus ();
  fp_side_if  side_bus ();

  fpdiv_ctrl fpdiv_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .ack         (ack),
    .dividend_in (dividend),
    .divisor_in  (divisor),
    .op_a        (op_a),
    .op_b        (op_b),
    .iter        (iter_bus.ctrl),
    .res_in      (res_word),
    .flags_in    (res_flags),
    .quotient    (quotient),
    .flags       (flags)
  );

  // mantissas go straight onto the core's side of the iteration bus
  fp_unpack fp_unpack_i (
    .a      (op_a),
    .b      (op_b),
    .side   (side_bus.src),
    .mant_a (iter_bus.mant_dividend),
    .mant_b (iter_bus.mant_divisor)
  );

  srt_radix4_core srt_radix4_core_i (
    .clk  (clk),
    .rst  (rst),
    .iter (iter_bus.core)
  );

  fp_round_pack fp_round_pack_i (
    .quot        (iter_bus.quot),
    .rem_nonzero (iter_bus.rem_nonzero),
    .side        (side_bus.dst),
    .result      (res_word),
    .flags       (res_flags)
  );

endmodule

// File: dv/tb_fp32_divider.sv
// testbench for the fp32 SRT divider
// pushes random, range-edge, special and back-pressure divisions through req/ack
// and checks every result against an integer model of the rounding rules
`timescale 1ns/10ps
`include "fpdiv_defs.svh"

module tb_fp32_divider
  import fpdiv_pkg::*;
();

  logic        clk;
  logic        rst;
  logic        req;
  logic        ack;
  logic [31:0] dividend;
  logic [31:0] divisor;
  logic [31:0] quotient;
  logic [4:0]  flags;
  logic [31:0] lfsr;          // stimulus state
  logic [31:0] cur_a, cur_b;  // operands in flight, for error lines

  fp32_divider fp32_divider_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .dividend (dividend),
    .divisor  (divisor),
    .quotient (quotient),
    .flags    (flags)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;   // 100 ns period

  task automatic report_and_stop(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input fp32_u expected, input fp32_u actual);
    if (actual.word !== expected.word) begin
      report_and_stop($sformatf("FAIL %s expected %08h actual %08h (dividend %08h divisor %08h)",
                                name, expected.word, actual.word, cur_a, cur_b));
    end
  endtask

  task automatic check_flags(input string name, input logic [4:0] expected,
                             input logic [4:0] actual);
    if (actual !== expected) begin
      report_and_stop($sformatf("FAIL %s expected %02h actual %02h (dividend %08h divisor %08h)",
                                name, expected, actual, cur_a, cur_b));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic fp32_u make_word(input logic s, input logic [7:0] e, input logic [22:0] f);
    fp32_u w;
    w.f.sign     = s;
    w.f.exponent = e;
    w.f.fraction = f;
    return w;
  endfunction

  // reference: long division of the mantissas, then RNE from guard and sticky
  function automatic void model_divide(input fp32_u a, input fp32_u b,
                                       output fp32_u res, output logic [4:0] fl);
    logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, s;
    logic [63:0] num, q, r;
    logic [24:0] m;
    logic        g, st, up;
    int          e;
    a_zero = (a.f.exponent == 8'h00);   // subnormals too
    b_zero = (b.f.exponent == 8'h00);
    a_inf  = (a.f.exponent == 8'hff) && (a.f.fraction == 23'h0);
    b_inf  = (b.f.exponent == 8'hff) && (b.f.fraction == 23'h0);
    a_nan  = (a.f.exponent == 8'hff) && (a.f.fraction != 23'h0);
    b_nan  = (b.f.exponent == 8'hff) && (b.f.fraction != 23'h0);
    s      = a.f.sign ^ b.f.sign;
    fl       = 5'h0;
    res.word = {s, 31'h0};
    if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
      res.word = 32'h7fc0_0000;
      fl[`FLAG_INVALID] = 1'b1;
    end else if (a_inf) begin
      res.word = {s, 8'hff, 23'h0};
    end else if (b_zero) begin
      res.word = {s, 8'hff, 23'h0};
      fl[`FLAG_DIVZERO] = 1'b1;
    end else if (!(a_zero || b_inf)) begin
      num = 64'({1'b1, a.f.fraction}) << 27;   // quotient lands in bit 27 or 26
      q   = num / 64'({1'b1, b.f.fraction});
      r   = num % 64'({1'b1, b.f.fraction});
      e   = int'(a.f.exponent) - int'(b.f.exponent) + `FPDIV_BIAS;
      if (q[27] == 1'b0) begin
        q = q << 1;                            // x < d
        e = e - 1;
      end
      g  = q[3];
      st = (q[2:0] != 3'b0) || (r != 64'd0);
      up = g && (st || q[4]);                  // ties to even
      m  = 25'(q[27:4]) + 25'(up);
      if (m[24]) begin
        m = m >> 1;
        e = e + 1;
      end
      fl[`FLAG_INEXACT] = g || st;
      if (e >= 255) begin
        res.word = {s, 8'hff, 23'h0};
        fl[`FLAG_OVERFLOW] = 1'b1;
        fl[`FLAG_INEXACT]  = 1'b1;
      end else if (e <= 0) begin
        res.word = {s, 31'h0};                 // flush
        fl[`FLAG_UNDERFLOW] = 1'b1;
        fl[`FLAG_INEXACT]   = 1'b1;
      end else begin
        res = make_word(s, 8'(e), m[22:0]);
      end
    end
  endfunction

  // one full four-phase handshake, req held for hold extra cycles
  task automatic run_op(input fp32_u a, input fp32_u b, input int hold);
    fp32_u      exp_res;
    logic [4:0] exp_fl;
    int         n;
    model_divide(a, b, exp_res, exp_fl);
    cur_a = a.word;
    cur_b = b.word;
    @(posedge clk);
    req      <= 1'b1;
    dividend <= a.word;
    divisor  <= b.word;
    @(posedge clk);                            // E0, req sampled
    n = 0;
    do begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (!ack && n == 40) report_and_stop("timeout: ack did not rise within 40 cycles");
    end while (!ack);
    if (n != 16) begin
      report_and_stop($sformatf("ack rose %0d edges after req was sampled instead of 16", n));
    end
    check_word("quotient", exp_res, quotient);
    check_flags("flags", exp_fl, flags);
    repeat (hold) begin                        // back-pressure, result must hold
      @(posedge clk);
      @(negedge clk);
      if (!ack) report_and_stop("ack dropped while req was still high");
      check_word("quotient", exp_res, quotient);
      check_flags("flags", exp_fl, flags);
    end
    @(posedge clk);
    req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      @(negedge clk);
      if (ack && n == 40) report_and_stop("timeout: ack did not fall within 40 cycles");
    end while (ack);
    if (n != 1) report_and_stop("ack did not fall on the edge after req was sampled low");
  endtask

  initial begin
    fp32_u       a, b;
    logic [7:0]  ea, eb;
    logic [31:0] specials [10];
    lfsr     = 32'hc5fd01b2;
    rst      = 1'b0;
    req      = 1'b0;
    dividend = 32'h0;
    divisor  = 32'h0;
    cur_a    = 32'h0;
    cur_b    = 32'h0;
    repeat (10) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    if (ack !== 1'b0) report_and_stop("ack is not low after reset");
    check_word("quotient", 32'h0, quotient);
    check_flags("flags", 5'h0, flags);

    // normal operands, exponents within 16 of the bias
    for (int i = 0; i < 2000; i++) begin
      a = make_word(1'(take_bits(1)), 8'(8'd112 + take_bits(5)), 23'(take_bits(23)));
      b = make_word(1'(take_bits(1)), 8'(8'd112 + take_bits(5)), 23'(take_bits(23)));
      if (i % 4 == 3) b.f.fraction = 23'h0;                          // exact quotient
      if (i % 4 == 2) b.f.fraction = {2'(take_bits(2)), 21'h0};      // short divisor
      run_op(a, b, 0);
    end

    // exponents around the top and bottom of the range
    for (int i = 0; i < 200; i++) begin
      if (i % 2 == 1) begin
        ea = 8'(8'd250 + take_bits(2));
        eb = 8'(8'd120 + take_bits(4));
      end else begin
        ea = 8'(8'd1 + take_bits(4));
        eb = 8'(8'd120 + take_bits(4));
      end
      a = make_word(1'(take_bits(1)), ea, 23'(take_bits(23)));
      b = make_word(1'(take_bits(1)), eb, 23'(take_bits(23)));
      run_op(a, b, 0);
    end

    // zeros, subnormals, infinities, nans and two normals, every pairing
    specials = '{32'h0000_0000, 32'h8000_0000, 32'h0012_3456, 32'h8000_0001, 32'h7f80_0000,
                 32'hff80_0000, 32'h7fc0_0000, 32'h7f80_0001, 32'h3fc0_0000, 32'hc040_0000};
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 10; j++) begin
        a.word = specials[i];
        b.word = specials[j];
        run_op(a, b, 0);
      end
    end

    // req held high for a few extra cycles
    for (int i = 0; i < 60; i++) begin
      a = make_word(1'(take_bits(1)), 8'(8'd112 + take_bits(5)), 23'(take_bits(23)));
      b = make_word(1'(take_bits(1)), 8'(8'd112 + take_bits(5)), 23'(take_bits(23)));
      run_op(a, b, int'(take_bits(3)));
    end

    $display("No errors");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+src
src/fpdiv_pkg.sv
src/fpdiv_ifs.sv
src/fp_unpack.sv
src/srt_qsel_table.sv
src/srt_radix4_core.sv
src/fp_round_pack.sv
src/fpdiv_ctrl.sv
src/fp32_divider.sv
dv/tb_fp32_divider.sv

// File: run.sh
#!/bin/sh
# build the fp32 divider testbench with Verilator and run it
# exit status is nonzero when the simulation stops on an error
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f filelist.f \
  --top-module tb_fp32_divider \
  --Mdir obj_dir \
  -o tb_fp32_divider

./obj_dir/tb_fp32_divider
